// ==== vlog.f ====
+incdir+.
alu_types_pkg.sv
alu_ctrl_pkg.sv
alu_decode.sv
serial_addsub.sv
muldiv_unit.sv
alu_result.sv
seq_alu.sv
tb_seq_alu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = tb_seq_alu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_seq_alu.sv ====
`default_nettype none

`include "alu_macros.svh"

module tb_seq_alu
    import alu_types_pkg::*;
    import alu_ctrl_pkg::*;
();

    localparam int DONE_TIMEOUT = 4 * `ALU_WIDTH + 20;
    localparam int RANDOM_OPS   = 300;
    localparam int BUSY_TRIALS  = 12;

    logic    clk;
    logic    reset;
    logic    start;
    alu_op_e opcode;
    word_t   in1;
    word_t   in2;
    word_t   out_high;
    word_t   out_low;
    logic    flag;
    logic    done;

    integer seed;

    seq_alu i_dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .opcode   (opcode),
        .in1      (in1),
        .in2      (in2),
        .out_high (out_high),
        .out_low  (out_low),
        .flag     (flag),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at time %0t: %s is %h, expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at time %0t: %s is %b, expected %b",
                                     $time, what, actual, expected));
        end
    endtask

    // Expected outputs straight from the arithmetic rules
    task automatic model_result(input alu_op_e op, input word_t a, input word_t b,
                                output word_t hi, output word_t lo, output logic fl);
        hi = '0;
        lo = '0;
        fl = 1'b0;
        case (op)
            OP_ADD: {fl, lo} = {1'b0, a} + {1'b0, b};
            OP_SUB: begin
                lo = a - b;
                fl = (a < b);
            end
            OP_MUL: {hi, lo} = dword_t'(a) * dword_t'(b);
            OP_DIV: begin
                // Divide by zero gives all-ones quotient, dividend as remainder
                if (b == '0) begin
                    hi = '1;
                    lo = a;
                end else begin
                    hi = a / b;
                    lo = a % b;
                end
            end
            OP_AND:  lo = a & b;
            OP_OR:   lo = a | b;
            OP_XOR:  lo = a ^ b;
            OP_NOT:  lo = ~a;
            default: lo = '0;
        endcase
    endtask

    task automatic draw_operation(input logic arith_only, output alu_op_e op,
                                  output word_t a, output word_t b);
        logic [31:0] r;
        r = $random(seed);
        if (arith_only) begin
            op = alu_op_e'({2'b00, r[1:0]});
        end else begin
            op = alu_op_e'(r[3:0]);
        end
        a = word_t'(r[15:8]);
        b = word_t'(r[23:16]);
    endtask

    // One-cycle start, then junk on the inputs
    task automatic pulse_start(input alu_op_e op, input word_t a, input word_t b);
        alu_op_e junk_op;
        word_t   junk_a;
        word_t   junk_b;
        @(posedge clk);
        #1;
        start  = 1'b1;
        opcode = op;
        in1    = a;
        in2    = b;
        @(posedge clk);
        #1;
        draw_operation(1'b0, junk_op, junk_a, junk_b);
        start  = 1'b0;
        opcode = junk_op;
        in1    = junk_a;
        in2    = junk_b;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            report_failure($sformatf("Timeout: done never arrived within %0d cycles",
                                     DONE_TIMEOUT));
        end
    endtask

    task automatic check_result(input alu_op_e op, input word_t a, input word_t b);
        word_t exp_hi;
        word_t exp_lo;
        logic  exp_fl;
        string ctx;
        model_result(op, a, b, exp_hi, exp_lo, exp_fl);
        ctx = $sformatf("opcode %0d a=%h b=%h", op, a, b);
        check_word({ctx, " out_high"}, out_high, exp_hi);
        check_word({ctx, " out_low"}, out_low, exp_lo);
        check_flag({ctx, " flag"}, flag, exp_fl);
        // done lasts a single cycle
        @(negedge clk);
        check_flag({ctx, " done one cycle later"}, done, 1'b0);
    endtask

    task automatic run_operation(input alu_op_e op, input word_t a, input word_t b);
        pulse_start(op, a, b);
        wait_for_done();
        check_result(op, a, b);
    endtask

    // Second start lands while the first operation is still running
    task automatic run_with_ignored_start(input alu_op_e op, input word_t a, input word_t b);
        alu_op_e op2;
        word_t   a2;
        word_t   b2;
        int      extra;
        pulse_start(op, a, b);
        repeat (3) @(posedge clk);
        #1;
        draw_operation(1'b0, op2, a2, b2);
        start  = 1'b1;
        opcode = op2;
        in1    = a2;
        in2    = b2;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_for_done();
        check_result(op, a, b);
        extra = 0;
        repeat (2 * DONE_TIMEOUT) begin
            @(negedge clk);
            if (done === 1'b1) begin
                extra++;
            end
        end
        if (extra != 0) begin
            report_failure("An ignored start still produced another done pulse");
        end
    endtask

    initial begin
        alu_op_e op;
        word_t   a;
        word_t   b;
        seed   = 88;
        reset  = 1'b1;
        start  = 1'b0;
        opcode = OP_ADD;
        in1    = '0;
        in2    = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Corner cases
        run_operation(OP_ADD, 8'hff, 8'h01);
        run_operation(OP_SUB, 8'h00, 8'h01);
        run_operation(OP_SUB, 8'h80, 8'h80);
        run_operation(OP_MUL, 8'hff, 8'hff);
        run_operation(OP_DIV, 8'h9a, 8'h00);
        run_operation(OP_DIV, 8'h07, 8'h09);
        run_operation(OP_NOT, 8'h5a, 8'h00);
        run_operation(alu_op_e'(4'd6), 8'h12, 8'h34);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            draw_operation(1'b0, op, a, b);
            run_operation(op, a, b);
        end

        for (int i = 0; i < BUSY_TRIALS; i++) begin
            draw_operation(1'b1, op, a, b);
            run_with_ignored_start(op, a, b);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== seq_alu.sv ====
`default_nettype none

module seq_alu
    import alu_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  alu_op_e opcode,
    input  word_t   in1,
    input  word_t   in2,
    output word_t   out_high,
    output word_t   out_low,
    output logic    flag,
    output logic    done
);

    word_t op_a;
    word_t op_b;
    logic  addsub_go;
    logic  sub_sel;
    logic  muldiv_go;
    logic  div_sel;
    logic  logic_valid;
    word_t logic_word;
    logic  addsub_done;
    word_t addsub_word;
    logic  addsub_flag;
    logic  muldiv_done;
    word_t res_high;
    word_t res_low;

    alu_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .opcode      (opcode),
        .in1         (in1),
        .in2         (in2),
        .addsub_done (addsub_done),
        .muldiv_done (muldiv_done),
        .op_a        (op_a),
        .op_b        (op_b),
        .addsub_go   (addsub_go),
        .sub_sel     (sub_sel),
        .muldiv_go   (muldiv_go),
        .div_sel     (div_sel),
        .logic_valid (logic_valid),
        .logic_word  (logic_word)
    );

    serial_addsub i_addsub (
        .clk         (clk),
        .reset       (reset),
        .addsub_go   (addsub_go),
        .sub_sel     (sub_sel),
        .op_a        (op_a),
        .op_b        (op_b),
        .addsub_done (addsub_done),
        .addsub_word (addsub_word),
        .addsub_flag (addsub_flag)
    );

    muldiv_unit i_muldiv (
        .clk         (clk),
        .reset       (reset),
        .muldiv_go   (muldiv_go),
        .div_sel     (div_sel),
        .op_a        (op_a),
        .op_b        (op_b),
        .muldiv_done (muldiv_done),
        .res_high    (res_high),
        .res_low     (res_low)
    );

    alu_result i_result (
        .clk         (clk),
        .reset       (reset),
        .addsub_done (addsub_done),
        .addsub_word (addsub_word),
        .addsub_flag (addsub_flag),
        .muldiv_done (muldiv_done),
        .res_high    (res_high),
        .res_low     (res_low),
        .logic_valid (logic_valid),
        .logic_word  (logic_word),
        .out_high    (out_high),
        .out_low     (out_low),
        .flag        (flag),
        .done        (done)
    );

endmodule

`default_nettype wire

// ==== alu_result.sv ====
`default_nettype none

module alu_result
    import alu_types_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  addsub_done,
    input  word_t addsub_word,
    input  logic  addsub_flag,
    input  logic  muldiv_done,
    input  word_t res_high,
    input  word_t res_low,
    input  logic  logic_valid,
    input  word_t logic_word,
    output word_t out_high,
    output word_t out_low,
    output logic  flag,
    output logic  done
);

    // Only one unit runs at a time, so at most one strobe is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_high <= '0;
            out_low  <= '0;
            flag     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= addsub_done | muldiv_done | logic_valid;
            if (addsub_done) begin
                out_high <= '0;
                out_low  <= addsub_word;
                flag     <= addsub_flag;
            end else if (muldiv_done) begin
                out_high <= res_high;
                out_low  <= res_low;
                flag     <= 1'b0;
            end else if (logic_valid) begin
                out_high <= '0;
                out_low  <= logic_word;
                flag     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== muldiv_unit.sv ====
`default_nettype none

`include "alu_macros.svh"

module muldiv_unit
    import alu_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  muldiv_go,
    input  logic  div_sel,
    input  word_t op_a,
    input  word_t op_b,
    output logic  muldiv_done,
    output word_t res_high,
    output word_t res_low
);

    localparam count_t LAST_STEP = count_t'(`ALU_WIDTH - 1);

    muldiv_state_e state;
    count_t        count;

    // Product, or quotient in the upper half and remainder in the lower
    dword_t acc;

    word_t              b_bits;
    dword_t             partial;
    word_t              a_bits;
    logic [`ALU_WIDTH:0] rem_shift;
    logic [`ALU_WIDTH:0] rem_diff;
    logic               no_borrow;

    always_comb begin
        // Multiplier bit and shifted multiplicand for this step
        b_bits  = op_b >> count;
        partial = dword_t'(op_a) << count;

        // Dividend bits are taken MSB first
        a_bits    = op_a >> (LAST_STEP - count);
        rem_shift = {acc[`ALU_WIDTH-1:0], a_bits[0]};
        rem_diff  = rem_shift - {1'b0, op_b};
        no_borrow = ~rem_diff[`ALU_WIDTH];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= MD_IDLE;
            count <= '0;
        end else begin
            case (state)
                MD_IDLE: begin
                    if (muldiv_go) begin
                        count <= '0;
                        state <= div_sel ? MD_DIV_RUN : MD_MUL_RUN;
                    end
                end
                MD_MUL_RUN, MD_DIV_RUN: begin
                    count <= count + count_t'(1);
                    if (count == LAST_STEP) begin
                        state <= MD_DONE;
                    end
                end
                default: begin
                    state <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            MD_IDLE: begin
                if (muldiv_go) begin
                    acc <= '0;
                end
            end
            MD_MUL_RUN: begin
                if (b_bits[0]) begin
                    acc <= acc + partial;
                end
            end
            MD_DIV_RUN: begin
                // Restore by keeping the shifted remainder when the subtract borrows
                if (no_borrow) begin
                    acc <= {acc[2*`ALU_WIDTH-2:`ALU_WIDTH], 1'b1, rem_diff[`ALU_WIDTH-1:0]};
                end else begin
                    acc <= {acc[2*`ALU_WIDTH-2:`ALU_WIDTH], 1'b0, rem_shift[`ALU_WIDTH-1:0]};
                end
            end
            default: begin
                acc <= acc;
            end
        endcase
    end

    assign muldiv_done = (state == MD_DONE);
    assign res_high    = acc[2*`ALU_WIDTH-1:`ALU_WIDTH];
    assign res_low     = acc[`ALU_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== serial_addsub.sv ====
`default_nettype none

`include "alu_macros.svh"

module serial_addsub
    import alu_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  addsub_go,
    input  logic  sub_sel,
    input  word_t op_a,
    input  word_t op_b,
    output logic  addsub_done,
    output word_t addsub_word,
    output logic  addsub_flag
);

    localparam count_t LAST_BIT = count_t'(`ALU_WIDTH - 1);

    addsub_state_e state;
    count_t        count;
    logic          carry;
    word_t         sum_reg;
    word_t         a_bits;
    word_t         b_bits;
    logic          a_bit;
    logic          b_bit;
    logic          sum_bit;
    logic          carry_next;

    // One full adder or full subtractor cell, shared across bits
    always_comb begin
        a_bits  = op_a >> count;
        b_bits  = op_b >> count;
        a_bit   = a_bits[0];
        b_bit   = b_bits[0];
        sum_bit = a_bit ^ b_bit ^ carry;
        if (sub_sel) begin
            // Borrow out of a - b - borrow_in
            carry_next = (~a_bit & b_bit) | (~(a_bit ^ b_bit) & carry);
        end else begin
            carry_next = (a_bit & b_bit) | ((a_bit ^ b_bit) & carry);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= AS_IDLE;
            count <= '0;
            carry <= 1'b0;
        end else begin
            case (state)
                AS_IDLE: begin
                    if (addsub_go) begin
                        count <= '0;
                        carry <= 1'b0;
                        state <= AS_RUN;
                    end
                end
                AS_RUN: begin
                    carry <= carry_next;
                    count <= count + count_t'(1);
                    if (count == LAST_BIT) begin
                        state <= AS_DONE;
                    end
                end
                default: begin
                    state <= AS_IDLE;
                end
            endcase
        end
    end

    // LSB first, so after the last step bit 0 sits at the bottom
    always_ff @(posedge clk) begin
        if (state == AS_RUN) begin
            sum_reg <= {sum_bit, sum_reg[`ALU_WIDTH-1:1]};
        end
    end

    assign addsub_done = (state == AS_DONE);
    assign addsub_word = sum_reg;
    assign addsub_flag = carry;

endmodule

`default_nettype wire

// ==== alu_decode.sv ====
`default_nettype none

module alu_decode
    import alu_types_pkg::*;
    import alu_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  alu_op_e opcode,
    input  word_t   in1,
    input  word_t   in2,
    input  logic    addsub_done,
    input  logic    muldiv_done,
    output word_t   op_a,
    output word_t   op_b,
    output logic    addsub_go,
    output logic    sub_sel,
    output logic    muldiv_go,
    output logic    div_sel,
    output logic    logic_valid,
    output word_t   logic_word
);

    logic  busy;
    logic  accept;
    logic  is_addsub;
    logic  is_muldiv;
    word_t logic_next;

    // Starts during an operation are dropped
    assign accept = start & ~busy;

    assign is_addsub = (opcode == OP_ADD) || (opcode == OP_SUB);
    assign is_muldiv = (opcode == OP_MUL) || (opcode == OP_DIV);

    // Unsupported opcodes fall through to zero
    always_comb begin
        case (opcode)
            OP_AND:  logic_next = in1 & in2;
            OP_OR:   logic_next = in1 | in2;
            OP_XOR:  logic_next = in1 ^ in2;
            OP_NOT:  logic_next = ~in1;
            default: logic_next = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            addsub_go   <= 1'b0;
            muldiv_go   <= 1'b0;
            logic_valid <= 1'b0;
        end else begin
            addsub_go   <= accept & is_addsub;
            muldiv_go   <= accept & is_muldiv;
            logic_valid <= accept & ~is_addsub & ~is_muldiv;
            if (accept) begin
                busy <= 1'b1;
            end else if (addsub_done || muldiv_done || logic_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Operands and selects stay put until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a       <= in1;
            op_b       <= in2;
            sub_sel    <= (opcode == OP_SUB);
            div_sel    <= (opcode == OP_DIV);
            logic_word <= logic_next;
        end
    end

endmodule

`default_nettype wire

// ==== alu_ctrl_pkg.sv ====
`default_nettype none

`include "alu_macros.svh"

package alu_ctrl_pkg;

    // Opcodes 4 to 8 and 13 to 15 are unsupported
    typedef enum logic [`ALU_OPCODE_WIDTH-1:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,
        OP_DIV = 4'd3,
        OP_AND = 4'd9,
        OP_OR  = 4'd10,
        OP_XOR = 4'd11,
        OP_NOT = 4'd12
    } alu_op_e;

    // Bit-serial adder/subtractor
    typedef enum logic [1:0] {
        AS_IDLE,
        AS_RUN,
        AS_DONE
    } addsub_state_e;

    // Multiplier/divider
    typedef enum logic [1:0] {
        MD_IDLE,
        MD_MUL_RUN,
        MD_DIV_RUN,
        MD_DONE
    } muldiv_state_e;

endpackage

`default_nettype wire

// ==== alu_types_pkg.sv ====
`default_nettype none

`include "alu_macros.svh"

package alu_types_pkg;

    // One operand, or one half of a result
    typedef logic [`ALU_WIDTH-1:0] word_t;

    // Full width product or quotient/remainder pair
    typedef logic [2*`ALU_WIDTH-1:0] dword_t;

    // Bit position counter for the multi-cycle units
    typedef logic [`ALU_COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// ==== alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Operand width in bits
`define ALU_WIDTH 8

// Opcode field width
`define ALU_OPCODE_WIDTH 4

// Step counter must reach ALU_WIDTH
`define ALU_COUNT_WIDTH 4

`endif
